// File: Makefile
TOOL    = verilator
FLAGS   = --binary --timing --assert -Wno-fatal
TOP     = tb_armDatapath
FLIST   = armDatapath.f
SRCS    = $(shell cat $(FLIST))
SIMBIN  = obj_dir/V$(TOP)
LOG     = sim.log
FAILMSG = STATUS: FAIL
PASSMSG = STATUS: PASS

.PHONY: run clean

run: $(SIMBIN)
	./$(SIMBIN) > $(LOG) 2>&1; cat $(LOG)
	@! grep -q "$(FAILMSG)" $(LOG)
	@grep -q "$(PASSMSG)" $(LOG)

$(SIMBIN): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir $(LOG)

// File: armAlu.sv
// ALU for the data-processing opcodes
`timescale 1ns/1ps

module armAlu (
  input  armDpPkg::aluOpE            aluOp,
  input  logic [armDpPkg::dataW-1:0] aOp,
  input  logic [armDpPkg::dataW-1:0] bOp,
  input  logic                       shiftCarry,
  input  logic [3:0]                 flagsIn,
  output logic [armDpPkg::dataW-1:0] result,
  output logic [3:0]                 flagsOut
);

  localparam int dataW = armDpPkg::dataW;
  localparam int msb = dataW - 1;

  logic [dataW-1:0] addX, addY, logicRes;
  logic addCin;
  logic isArith;
  logic [dataW:0] addSum;
  logic addV;

  // operand setup for the one shared adder
  always_comb begin
    addX = aOp;
    addY = bOp;
    addCin = 1'b0;
    isArith = 1'b1;
    logicRes = '0;
    case (aluOp)
      armDpPkg::opAnd, armDpPkg::opTst: begin
        isArith = 1'b0;
        logicRes = aOp & bOp;
      end
      armDpPkg::opEor, armDpPkg::opTeq: begin
        isArith = 1'b0;
        logicRes = aOp ^ bOp;
      end
      armDpPkg::opOrr: begin
        isArith = 1'b0;
        logicRes = aOp | bOp;
      end
      armDpPkg::opMov: begin
        isArith = 1'b0;
        logicRes = bOp;
      end
      armDpPkg::opBic: begin
        isArith = 1'b0;
        logicRes = aOp & ~bOp;
      end
      armDpPkg::opMvn: begin
        isArith = 1'b0;
        logicRes = ~bOp;
      end
      armDpPkg::opSub, armDpPkg::opCmp: begin
        addY = ~bOp; // a - b as a + ~b + 1
        addCin = 1'b1;
      end
      armDpPkg::opRsb: begin
        addX = bOp;
        addY = ~aOp;
        addCin = 1'b1;
      end
      armDpPkg::opAdd, armDpPkg::opCmn: addCin = 1'b0;
      armDpPkg::opAdc: addCin = flagsIn[armDpPkg::flagC];
      armDpPkg::opSbc: begin
        addY = ~bOp;
        addCin = flagsIn[armDpPkg::flagC]; // borrow is !C
      end
      armDpPkg::opRsc: begin
        addX = bOp;
        addY = ~aOp;
        addCin = flagsIn[armDpPkg::flagC];
      end
      default: isArith = 1'b1;
    endcase
  end

  assign addSum = {1'b0, addX} + {1'b0, addY} + {{dataW{1'b0}}, addCin};
  assign addV = (addX[msb] == addY[msb]) && (addSum[msb] != addX[msb]);

  assign result = isArith ? addSum[dataW-1:0] : logicRes;

  always_comb begin
    flagsOut[armDpPkg::flagN] = result[msb];
    flagsOut[armDpPkg::flagZ] = (result == '0);
    flagsOut[armDpPkg::flagC] = isArith ? addSum[dataW] : shiftCarry;
    flagsOut[armDpPkg::flagV] = isArith ? addV : flagsIn[armDpPkg::flagV]; // logical keeps V
  end

endmodule

// File: armDatapath.f
armDpPkg.sv
regFile.sv
operandStage.sv
barrelShift.sv
armAlu.sv
detectSkip.sv
resultStage.sv
armDatapath.sv
armDatapath_properties.sv
tb_armDatapath.sv

// File: armDatapath.sv
// ARM integer datapath top level
`timescale 1ns/1ps

module armDatapath #(
  parameter int numRegs = 16,
  parameter int shiftW = 5
) (
  input  logic                          phi1,
  input  logic                          rstN,
  input  logic                          opValid,
  output logic                          opReady,
  input  armDpPkg::aluOpE               aluOp,
  input  armDpPkg::condE                cond,
  input  logic [armDpPkg::regAddrW-1:0] rA,
  input  logic [armDpPkg::regAddrW-1:0] rB,
  input  logic [armDpPkg::regAddrW-1:0] rS,
  input  logic [armDpPkg::regAddrW-1:0] wA,
  input  armDpPkg::shiftTypeE           shiftType,
  input  logic [shiftW-1:0]             shiftAmt,
  input  logic                          shiftByReg,
  input  logic                          useImm,
  input  logic [armDpPkg::dataW-1:0]    imm,
  input  logic                          setFlags,
  output logic                          resValid,
  input  logic                          resReady,
  output logic [armDpPkg::dataW-1:0]    result,
  output logic [3:0]                    flags,
  output logic                          skipped
);

  logic [armDpPkg::dataW-1:0] rdA, rdB, rdS;
  logic [3:0] statFlags;
  logic exValid, exSetFlags, exAdvance, execute;
  armDpPkg::aluOpE exAluOp;
  armDpPkg::condE exCond;
  armDpPkg::shiftTypeE exShiftType;
  logic [armDpPkg::regAddrW-1:0] exWa, wrAddr;
  logic [armDpPkg::dataW-1:0] aOp, bOp, bShifted, aluResult, wrData;
  logic [shiftW-1:0] sAmt;
  logic shiftCarry, wrEn, flagsWrEn;
  logic [3:0] aluFlags, flagsIn;

  regFile #(.numRegs(numRegs)) regs (
    .phi1(phi1), .rstN(rstN),
    .rA(rA), .rB(rB), .rS(rS),
    .rdA(rdA), .rdB(rdB), .rdS(rdS),
    .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
    .flagsWrEn(flagsWrEn), .flagsIn(flagsIn), .flagsOut(statFlags)
  );

  operandStage #(.shiftW(shiftW)) opStage (
    .phi1(phi1), .rstN(rstN),
    .opValid(opValid), .opReady(opReady),
    .aluOp(aluOp), .cond(cond), .rA(rA), .rB(rB), .rS(rS), .wA(wA),
    .shiftType(shiftType), .shiftAmt(shiftAmt), .shiftByReg(shiftByReg),
    .useImm(useImm), .imm(imm), .setFlags(setFlags),
    .rdA(rdA), .rdB(rdB), .rdS(rdS),
    .exAdvance(exAdvance), .execute(execute), .fwdResult(aluResult),
    .exValid(exValid), .aOp(aOp), .bOp(bOp), .sAmt(sAmt),
    .exAluOp(exAluOp), .exCond(exCond), .exShiftType(exShiftType),
    .exWa(exWa), .exSetFlags(exSetFlags)
  );

  barrelShift #(.shiftW(shiftW)) shifter (
    .shiftType(exShiftType), .amount(sAmt), .operand(bOp),
    .carryIn(statFlags[armDpPkg::flagC]),
    .shifted(bShifted), .carryOut(shiftCarry)
  );

  armAlu alu (
    .aluOp(exAluOp), .aOp(aOp), .bOp(bShifted),
    .shiftCarry(shiftCarry), .flagsIn(statFlags),
    .result(aluResult), .flagsOut(aluFlags)
  );

  detectSkip skipDet (
    .cond(exCond), .flags(statFlags), .execute(execute)
  );

  resultStage resStage (
    .phi1(phi1), .rstN(rstN),
    .exValid(exValid), .execute(execute),
    .aluResult(aluResult), .aluFlags(aluFlags), .flagsCur(statFlags),
    .aluOp(exAluOp), .wA(exWa), .setFlags(exSetFlags),
    .resReady(resReady), .exAdvance(exAdvance),
    .resValid(resValid), .result(result), .flags(flags), .skipped(skipped),
    .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
    .flagsWrEn(flagsWrEn), .flagsIn(flagsIn)
  );

endmodule

// File: armDatapath_golden.txt
# name op cond rA rB rS wA shType shAmt byReg useImm imm setFlags (hex)
# then expected result, NZCV flags and skipped (hex)
movR1     d e 0 0 0 1 0 00 0 1 12345678 1 12345678 0 0
addR3     4 e 1 0 0 3 0 00 0 1 11111111 0 23456789 0 0
subR4     2 e 3 0 0 4 0 00 0 1 23456789 1 00000000 6 0
rsbR5     3 e 1 0 0 5 0 00 0 1 00000010 1 edcba998 8 0
andR6     0 e 1 0 0 6 0 00 0 1 0000ffff 1 00005678 0 0
orrR7     c e 6 0 0 7 0 00 0 1 f0000000 1 f0005678 8 0
eorR8     1 e 7 0 0 8 0 00 0 1 f0005678 1 00000000 4 0
bicR9     e e 1 0 0 9 0 00 0 1 0000ffff 0 12340000 4 0
mvnR10    f e 0 0 0 a 0 00 0 1 00000000 1 ffffffff 8 0
addsCarry 4 e a 0 0 b 0 00 0 1 00000001 1 00000000 6 0
adcR12    5 e 1 0 0 c 0 00 0 1 00000000 0 12345679 6 0
cmpOvf    a e 1 0 0 0 0 00 0 1 80000000 1 92345678 9 0
sbcR13    6 e 1 0 0 d 0 00 0 1 02345678 1 0fffffff 2 0
addsOvf   4 e d 0 0 e 0 00 0 1 70000001 1 80000000 9 0
lslImm    d e 0 1 0 2 0 04 0 0 00000000 1 23456780 3 0
lsrImm    d e 0 e 0 3 1 1f 0 0 00000000 1 00000001 1 0
asrImm    d e 0 e 0 4 2 04 0 0 00000000 1 f8000000 9 0
rorImm    d e 0 1 0 5 3 08 0 0 00000000 1 78123456 1 0
rorReg    d e 0 d 3 7 3 00 1 0 00000000 1 87ffffff b 0
shiftZero d e 0 1 0 8 0 00 1 0 00000000 1 12345678 3 0
chainAdd  4 e 9 9 0 9 0 00 0 0 00000000 0 24680000 3 0
chainSub  2 e 9 0 0 a 0 00 0 1 00000002 1 2467fffe 2 0
eqSkip    f 0 0 0 0 a 0 00 0 1 00000000 1 ffffffff 2 1
nvSkip    d f 0 0 0 a 0 00 0 1 00000000 1 00000000 2 1
ltSkip    2 b a 0 0 a 0 00 0 1 2467fffe 1 00000000 2 1
readBack  d e 0 a 0 b 0 00 0 0 00000000 1 2467fffe 2 0
geExec    4 a b 0 0 c 0 00 0 1 00000001 0 2467ffff 2 0

// File: armDatapath_properties.sv
// Datapath handshake assertions
`timescale 1ns/1ps

module armDatapath_properties (
  input logic                       phi1,
  input logic                       rstN,
  input logic                       resValid,
  input logic                       resReady,
  input logic [armDpPkg::dataW-1:0] result,
  input logic [3:0]                 flags,
  input logic                       skipped,
  input logic                       wrEn,
  input logic                       flagsWrEn,
  input logic                       execute,
  input armDpPkg::aluOpE            exAluOp
);

  // stalled result holds its value
  holdWhileStalled: assert property (@(posedge phi1) disable iff (!rstN)
    resValid && !resReady |=> resValid && $stable(result) && $stable(flags) && $stable(skipped))
    else $error("result port changed while stalled");

  idleAfterReset: assert property (@(posedge phi1) $rose(rstN) |-> !resValid)
    else $error("resValid high right after reset");

  // compares write flags only
  flagsWithWrite: assert property (@(posedge phi1) disable iff (!rstN)
    flagsWrEn |-> wrEn || (execute && (exAluOp == armDpPkg::opTst ||
      exAluOp == armDpPkg::opTeq || exAluOp == armDpPkg::opCmp || exAluOp == armDpPkg::opCmn)))
    else $error("flag write without register write or compare");

endmodule

// File: armDpPkg.sv
// ARM datapath shared definitions
package armDpPkg;

  localparam int dataW = 32;   // datapath word
  localparam int regAddrW = 4; // register address

  // data-processing opcodes, ARM encoding order
  typedef enum logic [3:0] {
    opAnd,
    opEor,
    opSub,
    opRsb,
    opAdd,
    opAdc,
    opSbc,
    opRsc,
    opTst,
    opTeq,
    opCmp,
    opCmn,
    opOrr,
    opMov,
    opBic,
    opMvn
  } aluOpE;

  typedef enum logic [1:0] {
    shLsl,
    shLsr,
    shAsr,
    shRor
  } shiftTypeE;

  // condition field, ARM order; cNv never executes
  typedef enum logic [3:0] {
    cEq, cNe, cCs, cCc,
    cMi, cPl, cVs, cVc,
    cHi, cLs, cGe, cLt,
    cGt, cLe, cAl, cNv
  } condE;

  // bit positions in the NZCV word
  localparam int flagN = 3;
  localparam int flagZ = 2;
  localparam int flagC = 1;
  localparam int flagV = 0;

  // test and compare opcodes only update flags
  function automatic logic writesReg(aluOpE op);
    return !(op inside {opTst, opTeq, opCmp, opCmn});
  endfunction

endpackage

// File: barrelShift.sv
// Barrel shifter for operand B
`timescale 1ns/1ps

module barrelShift #(
  parameter int shiftW = 5
) (
  input  armDpPkg::shiftTypeE        shiftType,
  input  logic [shiftW-1:0]          amount,
  input  logic [armDpPkg::dataW-1:0] operand,
  input  logic                       carryIn,
  output logic [armDpPkg::dataW-1:0] shifted,
  output logic                       carryOut
);

  localparam int dataW = armDpPkg::dataW;

  // one extra bit catches the last bit shifted out
  logic [dataW:0] lslExt;
  logic [dataW:0] lsrExt;
  logic [dataW:0] asrExt;
  logic [2*dataW-1:0] rorExt;

  assign lslExt = {1'b0, operand} << amount;
  assign lsrExt = {operand, 1'b0} >> amount;
  assign asrExt = $signed({operand, 1'b0}) >>> amount;
  assign rorExt = {operand, operand} >> amount;

  always_comb begin
    shifted = operand;  // amount zero passes through
    carryOut = carryIn;
    if (amount != '0) begin
      case (shiftType)
        armDpPkg::shLsl: {carryOut, shifted} = lslExt;
        armDpPkg::shLsr: {shifted, carryOut} = lsrExt;
        armDpPkg::shAsr: {shifted, carryOut} = asrExt;
        armDpPkg::shRor: begin
          shifted = rorExt[dataW-1:0];
          carryOut = rorExt[dataW-1]; // msb of rotated word
        end
        default: begin
          shifted = operand;
          carryOut = carryIn;
        end
      endcase
    end
  end

endmodule

// File: detectSkip.sv
// Condition code evaluation
`timescale 1ns/1ps

module detectSkip (
  input  armDpPkg::condE cond,
  input  logic [3:0]     flags,
  output logic           execute
);

  logic n, z, c, v;

  assign n = flags[armDpPkg::flagN];
  assign z = flags[armDpPkg::flagZ];
  assign c = flags[armDpPkg::flagC];
  assign v = flags[armDpPkg::flagV];

  always_comb begin
    case (cond)
      armDpPkg::cEq: execute = z;
      armDpPkg::cNe: execute = !z;
      armDpPkg::cCs: execute = c;
      armDpPkg::cCc: execute = !c;
      armDpPkg::cMi: execute = n;
      armDpPkg::cPl: execute = !n;
      armDpPkg::cVs: execute = v;
      armDpPkg::cVc: execute = !v;
      armDpPkg::cHi: execute = c && !z;
      armDpPkg::cLs: execute = !c || z;
      armDpPkg::cGe: execute = (n == v);
      armDpPkg::cLt: execute = (n != v);
      armDpPkg::cGt: execute = !z && (n == v);
      armDpPkg::cLe: execute = z || (n != v);
      armDpPkg::cAl: execute = 1'b1;
      default: execute = 1'b0; // NV
    endcase
  end

endmodule

// File: operandStage.sv
// Operand fetch and execute register
`timescale 1ns/1ps

module operandStage #(
  parameter int shiftW = 5
) (
  input  logic                          phi1,
  input  logic                          rstN,
  input  logic                          opValid,
  output logic                          opReady,
  input  armDpPkg::aluOpE               aluOp,
  input  armDpPkg::condE                cond,
  input  logic [armDpPkg::regAddrW-1:0] rA,
  input  logic [armDpPkg::regAddrW-1:0] rB,
  input  logic [armDpPkg::regAddrW-1:0] rS,
  input  logic [armDpPkg::regAddrW-1:0] wA,
  input  armDpPkg::shiftTypeE           shiftType,
  input  logic [shiftW-1:0]             shiftAmt,
  input  logic                          shiftByReg,
  input  logic                          useImm,
  input  logic [armDpPkg::dataW-1:0]    imm,
  input  logic                          setFlags,
  input  logic [armDpPkg::dataW-1:0]    rdA,
  input  logic [armDpPkg::dataW-1:0]    rdB,
  input  logic [armDpPkg::dataW-1:0]    rdS,
  input  logic                          exAdvance,
  input  logic                          execute,   // condition result of the held item
  input  logic [armDpPkg::dataW-1:0]    fwdResult,
  output logic                          exValid,
  output logic [armDpPkg::dataW-1:0]    aOp,
  output logic [armDpPkg::dataW-1:0]    bOp,
  output logic [shiftW-1:0]             sAmt,
  output armDpPkg::aluOpE               exAluOp,
  output armDpPkg::condE                exCond,
  output armDpPkg::shiftTypeE           exShiftType,
  output logic [armDpPkg::regAddrW-1:0] exWa,
  output logic                          exSetFlags
);

  logic exWrites;
  logic [armDpPkg::dataW-1:0] selA, selB, selS;

  // held item writes back on the edge a new request would be accepted
  assign exWrites = exValid && execute && armDpPkg::writesReg(exAluOp);

  assign selA = (exWrites && rA == exWa) ? fwdResult : rdA;
  assign selB = (exWrites && rB == exWa) ? fwdResult : rdB;
  assign selS = (exWrites && rS == exWa) ? fwdResult : rdS;

  assign opReady = !exValid || exAdvance;

  always_ff @(posedge phi1 or negedge rstN) begin
    if (!rstN) begin
      exValid <= 1'b0;
    end else if (opReady) begin
      exValid <= opValid;
    end
  end

  always_ff @(posedge phi1) begin
    if (opValid && opReady) begin
      aOp <= selA;
      bOp <= useImm ? imm : selB;
      sAmt <= shiftByReg ? selS[shiftW-1:0] : shiftAmt; // low bits of Rs
      exAluOp <= aluOp;
      exCond <= cond;
      exShiftType <= shiftType;
      exWa <= wA;
      exSetFlags <= setFlags;
    end
  end

endmodule

// File: regFile.sv
// Register file and NZCV status
`timescale 1ns/1ps

module regFile #(
  parameter int numRegs = 16
) (
  input  logic                          phi1,
  input  logic                          rstN,
  input  logic [armDpPkg::regAddrW-1:0] rA,
  input  logic [armDpPkg::regAddrW-1:0] rB,
  input  logic [armDpPkg::regAddrW-1:0] rS,
  output logic [armDpPkg::dataW-1:0]    rdA,
  output logic [armDpPkg::dataW-1:0]    rdB,
  output logic [armDpPkg::dataW-1:0]    rdS,
  input  logic                          wrEn,
  input  logic [armDpPkg::regAddrW-1:0] wrAddr,
  input  logic [armDpPkg::dataW-1:0]    wrData,
  input  logic                          flagsWrEn,
  input  logic [3:0]                    flagsIn,
  output logic [3:0]                    flagsOut
);

  localparam int idxW = $clog2(numRegs);

  logic [armDpPkg::dataW-1:0] regs [numRegs];
  logic [3:0] stat; // NZCV

  // combinational reads, forwarding handled upstream
  assign rdA = regs[rA[idxW-1:0]];
  assign rdB = regs[rB[idxW-1:0]];
  assign rdS = regs[rS[idxW-1:0]];
  assign flagsOut = stat;

  always_ff @(posedge phi1 or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wrAddr[idxW-1:0]] <= wrData;
    end
  end

  always_ff @(posedge phi1 or negedge rstN) begin
    if (!rstN) begin
      stat <= '0;
    end else if (flagsWrEn) begin
      stat <= flagsIn;
    end
  end

endmodule

// File: resultStage.sv
// Result register and write-back
`timescale 1ns/1ps

module resultStage (
  input  logic                          phi1,
  input  logic                          rstN,
  input  logic                          exValid,
  input  logic                          execute,
  input  logic [armDpPkg::dataW-1:0]    aluResult,
  input  logic [3:0]                    aluFlags,
  input  logic [3:0]                    flagsCur,  // flags before this item
  input  armDpPkg::aluOpE               aluOp,
  input  logic [armDpPkg::regAddrW-1:0] wA,
  input  logic                          setFlags,
  input  logic                          resReady,
  output logic                          exAdvance,
  output logic                          resValid,
  output logic [armDpPkg::dataW-1:0]    result,
  output logic [3:0]                    flags,
  output logic                          skipped,
  output logic                          wrEn,
  output logic [armDpPkg::regAddrW-1:0] wrAddr,
  output logic [armDpPkg::dataW-1:0]    wrData,
  output logic                          flagsWrEn,
  output logic [3:0]                    flagsIn
);

  logic capture;

  assign exAdvance = !resValid || resReady; // free or draining now
  assign capture = exValid && exAdvance;

  // write-back happens once, on the capture edge
  assign wrEn = capture && execute && armDpPkg::writesReg(aluOp);
  assign wrAddr = wA;
  assign wrData = aluResult;
  assign flagsWrEn = capture && execute && setFlags;
  assign flagsIn = aluFlags;

  always_ff @(posedge phi1 or negedge rstN) begin
    if (!rstN) begin
      resValid <= 1'b0;
    end else if (exAdvance) begin
      resValid <= exValid;
    end
  end

  always_ff @(posedge phi1) begin
    if (capture) begin
      result <= aluResult;
      flags <= flagsWrEn ? aluFlags : flagsCur;
      skipped <= !execute;
    end
  end

endmodule

// File: tb_armDatapath.sv
// ARM datapath testbench
`timescale 1ns/1ps

module tb_armDatapath;

  localparam int maxTests = 64;
  localparam int timeoutCycles = 200;
  localparam int quietTests = 8; // resReady held high, latency checked

  logic phi1;
  logic rstN;
  logic opValid, opReady;
  armDpPkg::aluOpE aluOp;
  armDpPkg::condE cond;
  armDpPkg::shiftTypeE shiftType;
  logic [3:0] rA, rB, rS, wA;
  logic [4:0] shiftAmt;
  logic shiftByReg, useImm, setFlags;
  logic [31:0] imm;
  logic resValid, resReady, skipped;
  logic [31:0] result;
  logic [3:0] flags;

  // per line: op cond rA rB rS wA shType shAmt byReg useImm imm setFlags expRes expFlags expSkip
  logic [127:0] names [maxTests];
  logic [31:0] vec [maxTests][15];
  int acceptCycle [maxTests];
  int numTests, errors, cycle;
  logic timedOut;
  logic [31:0] rngState;

  armDatapath #(.numRegs(16), .shiftW(5)) armDatapath_inst (.*);

  bind armDatapath armDatapath_properties props (
    .phi1(phi1), .rstN(rstN), .resValid(resValid), .resReady(resReady),
    .result(result), .flags(flags), .skipped(skipped), .wrEn(wrEn),
    .flagsWrEn(flagsWrEn), .execute(execute), .exAluOp(exAluOp)
  );

  always #20 phi1 = ~phi1;

  always @(posedge phi1) cycle <= cycle + 1;

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic checkValue(input logic [127:0] name, input string what,
                            input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("** Error %0s %0s: expected %h, actual %h", name, what, expected, actual);
    end
  endtask

  task automatic loadGolden(output int count);
    int fd, n;
    string line;
    count = 0;
    fd = $fopen("armDatapath_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file armDatapath_golden.txt");
      errors++;
      return;
    end
    while (!$feof(fd) && count < maxTests) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line[0] != "#") begin
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    names[count], vec[count][0], vec[count][1], vec[count][2],
                    vec[count][3], vec[count][4], vec[count][5], vec[count][6],
                    vec[count][7], vec[count][8], vec[count][9], vec[count][10],
                    vec[count][11], vec[count][12], vec[count][13], vec[count][14]);
        if (n == 16) begin
          count++;
        end else begin
          $display("malformed vector line: %s", line);
          errors++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic driveRequests();
    int waits;
    for (int i = 0; i < numTests; i++) begin
      aluOp <= armDpPkg::aluOpE'(vec[i][0][3:0]);
      cond <= armDpPkg::condE'(vec[i][1][3:0]);
      rA <= vec[i][2][3:0];
      rB <= vec[i][3][3:0];
      rS <= vec[i][4][3:0];
      wA <= vec[i][5][3:0];
      shiftType <= armDpPkg::shiftTypeE'(vec[i][6][1:0]);
      shiftAmt <= vec[i][7][4:0];
      shiftByReg <= vec[i][8][0];
      useImm <= vec[i][9][0];
      imm <= vec[i][10];
      setFlags <= vec[i][11][0];
      opValid <= 1'b1;
      waits = 0;
      do begin
        @(posedge phi1);
        waits++;
      end while (!opReady && waits < timeoutCycles);
      if (!opReady) begin
        $display("request %0s was not accepted within %0d cycles", names[i], timeoutCycles);
        timedOut = 1'b1;
        break;
      end
      acceptCycle[i] = cycle; // handshake on this edge
    end
    opValid <= 1'b0;
  endtask

  task automatic collectResults();
    int waits, errsBefore, next;
    logic got;
    for (int j = 0; j < numTests; j++) begin
      waits = 0;
      got = 1'b0;
      while (!got && waits < timeoutCycles) begin
        @(posedge phi1);
        waits++;
        got = resValid && resReady;
        next = got ? j + 1 : j;
        rngState = xorshift(rngState);
        resReady <= (next < quietTests) || (rngState[1:0] != 2'b00); // ~25% stall
      end
      if (!got) begin
        $display("no result for %0s within %0d cycles", names[j], timeoutCycles);
        timedOut = 1'b1;
        break;
      end
      errsBefore = errors;
      checkValue(names[j], "result", vec[j][12], result);
      checkValue(names[j], "flags", vec[j][13], {28'b0, flags});
      checkValue(names[j], "skipped", vec[j][14], {31'b0, skipped});
      if (j < quietTests) begin
        checkValue(names[j], "latency", 32'd2, cycle - acceptCycle[j]);
      end
      $display("%0s: %0s", names[j], (errors == errsBefore) ? "ok" : "mismatch");
    end
    resReady <= 1'b1;
    if (!timedOut) begin
      repeat (4) begin
        @(posedge phi1);
        if (resValid) begin
          $display("an extra result appeared after the last expected one");
          errors++;
        end
      end
    end
  endtask

  initial begin
    phi1 = 1'b0;
    rstN = 1'b0;
    opValid = 1'b0;
    aluOp = armDpPkg::opAnd;
    cond = armDpPkg::cAl;
    rA = '0;
    rB = '0;
    rS = '0;
    wA = '0;
    shiftType = armDpPkg::shLsl;
    shiftAmt = '0;
    shiftByReg = 1'b0;
    useImm = 1'b0;
    imm = '0;
    setFlags = 1'b0;
    resReady = 1'b1;
    errors = 0;
    cycle = 0;
    timedOut = 1'b0;
    rngState = 32'hb5c5;
    loadGolden(numTests);
    repeat (8) @(posedge phi1);
    rstN <= 1'b1;
    fork
      driveRequests();
      collectResults();
    join
    $display("tests %0d, errors %0d, timeouts %0d", numTests, errors, timedOut);
    if (errors == 0 && !timedOut && numTests > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
